// ==== wr_monitor_top.f ====
rtl/wr_monitor_pkg.sv
rtl/ht_lookup.sv
rtl/txn_manager.sv
rtl/txn_table.sv
rtl/monitor_regs.sv
rtl/wr_monitor_top.sv
tb/wr_monitor_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it, the exit status is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module wr_monitor_tb -f wr_monitor_top.f \
  && ./obj_dir/Vwr_monitor_tb \
  || { echo "simulation did not pass"; exit 1; }

// ==== tb/wr_monitor_tb.sv ====
/*
  Write monitor testbench
  Directed scenarios for in-order completion, unwanted responses,
  timeouts, flush and recovery, and a full table
*/
`default_nettype none

module wr_monitor_tb import wr_monitor_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MaxWrTxns    = 4;
  localparam int unsigned HtCapacity   = 4;
  localparam int unsigned PrescalerDiv = 1;
  // Longest scenario stays below about 60 cycles, doubled for margin
  localparam int unsigned ScenarioCycles = 60;
  localparam int unsigned TimeoutCycles  = 2 * (6 * ScenarioCycles) + 4;

  logic clk_i, rst_i;
  logic aw_valid_i, aw_ready_i, b_valid_i, b_ready_i;
  id_t  aw_id_i, b_id_i;
  len_t aw_len_i;
  logic aw_valid_o, aw_ready_o, irq_o, reset_req_o;
  logic reg_we_i;
  logic [RegAddrWidth-1:0] reg_addr_i;
  logic [RegDataWidth-1:0] reg_wdata_i, reg_rdata_o;

  logic [BudgetWidth-1:0] cfg_budget;
  accu_cnt_t              cfg_accum;
  accu_cnt_t              budget_q[$];
  integer                 seed = 51;
  int unsigned            cycle_cnt = 0;

  wr_monitor_top #(
    .MaxWrTxns   (MaxWrTxns),
    .HtCapacity  (HtCapacity),
    .PrescalerDiv(PrescalerDiv)
  ) wr_monitor_top_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .aw_valid_i (aw_valid_i),
    .aw_id_i    (aw_id_i),
    .aw_len_i   (aw_len_i),
    .b_ready_i  (b_ready_i),
    .aw_ready_i (aw_ready_i),
    .b_valid_i  (b_valid_i),
    .b_id_i     (b_id_i),
    .aw_valid_o (aw_valid_o),
    .aw_ready_o (aw_ready_o),
    .reg_we_i   (reg_we_i),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_rdata_o(reg_rdata_o),
    .irq_o      (irq_o),
    .reset_req_o(reset_req_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TimeoutCycles) begin
      stop_with_failure($sformatf("Run did not finish within %0d cycles", TimeoutCycles));
    end
  end

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_cnt(input string name, input accu_cnt_t got, input accu_cnt_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input logic [RegDataWidth-1:0] got,
                            input logic [RegDataWidth-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Remaining budget of a completed write lies in 1 to its full budget
  task automatic check_latency(input string name, input accu_cnt_t got, input accu_cnt_t max);
    if (got == '0 || got > max) begin
      stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x1 to 0x%0h",
                                  name, got, max));
    end
  endtask

  function automatic accu_cnt_t expected_budget(input logic [BudgetWidth-1:0] bw,
                                                input accu_cnt_t accum, input len_t len);
    int total;
    total = int'(bw) * int'(accum) + (int'(bw) * (int'(len) + 1)) / int'(PrescalerDiv) + 1;
    return accu_cnt_t'(total);
  endfunction

  task automatic reg_write(input logic [RegAddrWidth-1:0] addr,
                           input logic [RegDataWidth-1:0] data);
    @(posedge clk_i);
    #2;
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(posedge clk_i);
    #2;
    reg_we_i = 1'b0;
  endtask

  task automatic reg_read(input logic [RegAddrWidth-1:0] addr,
                          output logic [RegDataWidth-1:0] data);
    @(posedge clk_i);
    #2;
    reg_addr_i = addr;
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  task automatic set_budget(input logic [BudgetWidth-1:0] bw, input accu_cnt_t accum);
    reg_write(RegBudget, RegDataWidth'(bw));
    reg_write(RegAccum, accum);
    cfg_budget = bw;
    cfg_accum  = accum;
  endtask

  task automatic clear_status();
    reg_write(RegIrq, 16'h000F);
    @(negedge clk_i);
    check_flag("irq_o", irq_o, 1'b0);
    check_flag("reset_req_o", reset_req_o, 1'b0);
  endtask

  // Holds AW valid until the gate lets the handshake through
  task automatic aw_send(input id_t id, input len_t len);
    @(posedge clk_i);
    #2;
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_len_i   = len;
    @(negedge clk_i);
    while (!aw_ready_o) begin
      @(negedge clk_i);
    end
    check_flag("aw_valid_o", aw_valid_o, 1'b1);
    @(posedge clk_i);
    #2;
    aw_valid_i = 1'b0;
  endtask

  task automatic b_send(input id_t id);
    @(posedge clk_i);
    #2;
    b_valid_i = 1'b1;
    b_id_i    = id;
    @(posedge clk_i);
    #2;
    b_valid_i = 1'b0;
  endtask

  task automatic issue_write(input id_t id, input len_t len);
    aw_send(id, len);
    budget_q.push_back(expected_budget(cfg_budget, cfg_accum, len));
  endtask

  task automatic complete_write(input id_t id);
    logic [RegDataWidth-1:0] rdata;
    accu_cnt_t               budget;
    budget = budget_q.pop_front();
    b_send(id);
    reg_read(RegLatency, rdata);
    check_latency("RegLatency", rdata, budget);
    check_flag("irq_o", irq_o, 1'b0);
  endtask

  task automatic reset_and_registers();
    logic [RegDataWidth-1:0] rdata;
    @(negedge clk_i);
    check_flag("irq_o", irq_o, 1'b0);
    check_flag("reset_req_o", reset_req_o, 1'b0);
    check_flag("aw_valid_o", aw_valid_o, 1'b0);
    reg_read(RegIrq, rdata);
    check_data("RegIrq", rdata, '0);
    set_budget(3'd5, 16'h1234);
    reg_read(RegBudget, rdata);
    check_data("RegBudget", rdata, 16'h0005);
    reg_read(RegAccum, rdata);
    check_cnt("RegAccum", rdata, 16'h1234);
  endtask

  task automatic in_order_completion();
    id_t  ids [4];
    len_t len;
    ids = '{4'h1, 4'h2, 4'h1, 4'h3};
    set_budget(3'd3, 16'd20);
    foreach (ids[k]) begin
      len = len_t'($random(seed));
      issue_write(ids[k], len);
    end
    foreach (ids[k]) begin
      complete_write(ids[k]);
    end
    check_flag("reset_req_o", reset_req_o, 1'b0);
  endtask

  task automatic unwanted_response();
    logic [RegDataWidth-1:0] rdata;
    b_send(4'h5);
    @(negedge clk_i);
    check_flag("irq_o", irq_o, 1'b1);
    check_flag("reset_req_o", reset_req_o, 1'b1);
    reg_read(RegIrq, rdata);
    check_data("RegIrq", rdata,
               RegDataWidth'((1 << IrqBitUnwanted) | (1 << IrqBitIrq) | (1 << IrqBitReset)));
    reg_read(RegTxnId, rdata);
    check_id("RegTxnId", rdata[IdWidth-1:0], 4'h5);
    clear_status();
  endtask

  task automatic timeout_write();
    logic [RegDataWidth-1:0] rdata;
    accu_cnt_t               budget;
    int                      waited;
    set_budget(3'd1, 16'd0);
    budget = expected_budget(cfg_budget, cfg_accum, 8'd2);
    aw_send(4'h6, 8'd2);
    waited = 0;
    @(negedge clk_i);
    while (!irq_o) begin
      waited++;
      if (waited > int'(budget) + 3) begin
        stop_with_failure("irq_o did not rise after the budget of an unanswered write ran out");
      end
      @(negedge clk_i);
    end
    check_flag("reset_req_o", reset_req_o, 1'b1);
    reg_read(RegIrq, rdata);
    check_data("RegIrq", rdata,
               RegDataWidth'((1 << IrqBitTimeout) | (1 << IrqBitIrq) | (1 << IrqBitReset)));
    reg_read(RegTxnId, rdata);
    check_id("RegTxnId", rdata[IdWidth-1:0], 4'h6);
  endtask

  task automatic flush_and_recovery();
    logic [RegDataWidth-1:0] rdata;
    check_flag("reset_req_o", reset_req_o, 1'b1);
    @(posedge clk_i);
    #2;
    aw_valid_i = 1'b1;
    aw_id_i    = 4'h7;
    aw_len_i   = '0;
    repeat (3) begin
      @(negedge clk_i);
      check_flag("aw_ready_o", aw_ready_o, 1'b0);
      check_flag("aw_valid_o", aw_valid_o, 1'b0);
    end
    @(posedge clk_i);
    #2;
    aw_valid_i = 1'b0;
    clear_status();
    reg_read(RegIrq, rdata);
    check_data("RegIrq", rdata, '0);
    set_budget(3'd3, 16'd20);
    issue_write(4'h7, 8'd4);
    complete_write(4'h7);
  endtask

  task automatic full_table();
    int waited;
    for (int k = 0; k < MaxWrTxns; k++) begin
      issue_write(id_t'(8 + k % 3), len_t'(k));
    end
    @(posedge clk_i);
    #2;
    aw_valid_i = 1'b1;
    aw_id_i    = 4'hB;
    aw_len_i   = '0;
    @(negedge clk_i);
    check_flag("aw_ready_o", aw_ready_o, 1'b0);
    check_flag("aw_valid_o", aw_valid_o, 1'b0);
    @(posedge clk_i);
    #2;
    aw_valid_i = 1'b0;
    complete_write(4'h8);
    // Freed slot must reopen the gate within a few cycles
    waited = 0;
    while (!aw_ready_o) begin
      waited++;
      if (waited > 3) begin
        stop_with_failure("AW gate stayed closed after a completion freed a slot");
      end
      @(negedge clk_i);
    end
    issue_write(4'hB, 8'd0);
    for (int k = 1; k < MaxWrTxns; k++) begin
      complete_write(id_t'(8 + k % 3));
    end
    complete_write(4'hB);
    check_flag("reset_req_o", reset_req_o, 1'b0);
  endtask

  initial begin
    rst_i       = 1'b1;
    aw_valid_i  = 1'b0;
    aw_ready_i  = 1'b0;
    aw_id_i     = '0;
    aw_len_i    = '0;
    b_valid_i   = 1'b0;
    b_ready_i   = 1'b0;
    b_id_i      = '0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    cfg_budget  = '0;
    cfg_accum   = '0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_i      = 1'b0;
    // Slave always accepts AW and master always accepts B
    aw_ready_i = 1'b1;
    b_ready_i  = 1'b1;

    reset_and_registers();
    in_order_completion();
    unwanted_response();
    timeout_write();
    flush_and_recovery();
    full_table();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/wr_monitor_top.sv ====
/*
  Write transaction timeout monitor
  Gates AW between master and slave, tracks outstanding writes per ID
  and flags timeouts and unwanted B responses
*/
`default_nettype none

module wr_monitor_top import wr_monitor_pkg::*; #(
  parameter int unsigned MaxWrTxns    = 4,
  parameter int unsigned HtCapacity   = 4,
  parameter int unsigned PrescalerDiv = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    aw_valid_i,
  input  id_t                     aw_id_i,
  input  len_t                    aw_len_i,
  input  logic                    b_ready_i,
  input  logic                    aw_ready_i,
  input  logic                    b_valid_i,
  input  id_t                     b_id_i,
  output logic                    aw_valid_o,
  output logic                    aw_ready_o,
  input  logic                    reg_we_i,
  input  logic [RegAddrWidth-1:0] reg_addr_i,
  input  logic [RegDataWidth-1:0] reg_wdata_i,
  output logic [RegDataWidth-1:0] reg_rdata_o,
  output logic                    irq_o,
  output logic                    reset_req_o
);

  head_tail_t [HtCapacity-1:0]  head_tail_q, head_tail_d;
  linked_data_t [MaxWrTxns-1:0] linked_data_q, linked_data_d;
  id_t       match_in_id, match_out_id, evt_id;
  logic      no_in_match, no_out_match, ht_free, ld_free;
  idx_t      in_idx, out_idx, ht_free_idx, ld_free_idx;
  logic      timeout_evt, unwanted_evt, done_evt;
  accu_cnt_t done_latency, accum_burst_length;
  logic [BudgetWidth-1:0] budget_write;

  ht_lookup #(
    .MaxWrTxns (MaxWrTxns),
    .HtCapacity(HtCapacity)
  ) ht_lookup_i (
    .head_tail_q_i  (head_tail_q),
    .linked_data_q_i(linked_data_q),
    .match_in_id_i  (match_in_id),
    .match_out_id_i (match_out_id),
    .no_in_match_o  (no_in_match),
    .in_idx_o       (in_idx),
    .no_out_match_o (no_out_match),
    .out_idx_o      (out_idx),
    .ht_free_idx_o  (ht_free_idx),
    .ht_free_o      (ht_free),
    .ld_free_idx_o  (ld_free_idx),
    .ld_free_o      (ld_free)
  );

  txn_manager #(
    .MaxWrTxns   (MaxWrTxns),
    .HtCapacity  (HtCapacity),
    .PrescalerDiv(PrescalerDiv)
  ) txn_manager_i (
    .aw_valid_i          (aw_valid_i),
    .aw_ready_i          (aw_ready_i),
    .aw_id_i             (aw_id_i),
    .aw_len_i            (aw_len_i),
    .b_valid_i           (b_valid_i),
    .b_ready_i           (b_ready_i),
    .b_id_i              (b_id_i),
    .aw_valid_o          (aw_valid_o),
    .aw_ready_o          (aw_ready_o),
    .budget_write_i      (budget_write),
    .accum_burst_length_i(accum_burst_length),
    .reset_req_q_i       (reset_req_o),
    .no_in_match_i       (no_in_match),
    .in_idx_i            (in_idx),
    .no_out_match_i      (no_out_match),
    .out_idx_i           (out_idx),
    .ht_free_idx_i       (ht_free_idx),
    .ht_free_i           (ht_free),
    .ld_free_idx_i       (ld_free_idx),
    .ld_free_i           (ld_free),
    .head_tail_q_i       (head_tail_q),
    .linked_data_q_i     (linked_data_q),
    .match_in_id_o       (match_in_id),
    .match_out_id_o      (match_out_id),
    .head_tail_d_o       (head_tail_d),
    .linked_data_d_o     (linked_data_d),
    .timeout_evt_o       (timeout_evt),
    .unwanted_evt_o      (unwanted_evt),
    .done_evt_o          (done_evt),
    .done_latency_o      (done_latency),
    .evt_id_o            (evt_id)
  );

  txn_table #(
    .MaxWrTxns   (MaxWrTxns),
    .HtCapacity  (HtCapacity),
    .PrescalerDiv(PrescalerDiv)
  ) txn_table_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .head_tail_d_i  (head_tail_d),
    .linked_data_d_i(linked_data_d),
    .head_tail_q_o  (head_tail_q),
    .linked_data_q_o(linked_data_q)
  );

  monitor_regs monitor_regs_i (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .reg_we_i            (reg_we_i),
    .reg_addr_i          (reg_addr_i),
    .reg_wdata_i         (reg_wdata_i),
    .timeout_evt_i       (timeout_evt),
    .unwanted_evt_i      (unwanted_evt),
    .done_evt_i          (done_evt),
    .done_latency_i      (done_latency),
    .evt_id_i            (evt_id),
    .reg_rdata_o         (reg_rdata_o),
    .budget_write_o      (budget_write),
    .accum_burst_length_o(accum_burst_length),
    .reset_req_o         (reset_req_o),
    .irq_o               (irq_o)
  );

endmodule

`default_nettype wire

// ==== rtl/monitor_regs.sv ====
/*
  Monitor registers
  Budget configuration, sticky interrupt status, captured ID and latency,
  and the held reset request
*/
`default_nettype none

module monitor_regs import wr_monitor_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    reg_we_i,
  input  logic [RegAddrWidth-1:0] reg_addr_i,
  input  logic [RegDataWidth-1:0] reg_wdata_i,
  input  logic                    timeout_evt_i,
  input  logic                    unwanted_evt_i,
  input  logic                    done_evt_i,
  input  accu_cnt_t               done_latency_i,
  input  id_t                     evt_id_i,
  output logic [RegDataWidth-1:0] reg_rdata_o,
  output logic [BudgetWidth-1:0]  budget_write_o,
  output accu_cnt_t               accum_burst_length_o,
  output logic                    reset_req_o,
  output logic                    irq_o
);

  logic      sts_timeout_q, sts_unwanted_q;
  id_t       txn_id_q;
  accu_cnt_t latency_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      budget_write_o       <= '0;
      accum_burst_length_o <= '0;
      sts_timeout_q        <= 1'b0;
      sts_unwanted_q       <= 1'b0;
      irq_o                <= 1'b0;
      reset_req_o          <= 1'b0;
      txn_id_q             <= '0;
      latency_q            <= '0;
    end else begin
      if (reg_we_i) begin
        case (reg_addr_i)
          RegBudget: budget_write_o <= reg_wdata_i[BudgetWidth-1:0];
          RegAccum:  accum_burst_length_o <= reg_wdata_i;
          RegIrq: begin
            // Write 1 to clear
            if (reg_wdata_i[IrqBitTimeout])  sts_timeout_q  <= 1'b0;
            if (reg_wdata_i[IrqBitUnwanted]) sts_unwanted_q <= 1'b0;
            if (reg_wdata_i[IrqBitIrq])      irq_o          <= 1'b0;
            if (reg_wdata_i[IrqBitReset])    reset_req_o    <= 1'b0;
          end
          default: ;
        endcase
      end
      // Hardware events win over a clear in the same cycle
      if (timeout_evt_i || unwanted_evt_i) begin
        irq_o       <= 1'b1;
        reset_req_o <= 1'b1;
        txn_id_q    <= evt_id_i;
      end
      if (timeout_evt_i) begin
        sts_timeout_q <= 1'b1;
      end
      if (unwanted_evt_i) begin
        sts_unwanted_q <= 1'b1;
      end
      if (done_evt_i) begin
        latency_q <= done_latency_i;
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      RegBudget:  reg_rdata_o[BudgetWidth-1:0] = budget_write_o;
      RegAccum:   reg_rdata_o = accum_burst_length_o;
      RegIrq: begin
        reg_rdata_o[IrqBitTimeout]  = sts_timeout_q;
        reg_rdata_o[IrqBitUnwanted] = sts_unwanted_q;
        reg_rdata_o[IrqBitIrq]      = irq_o;
        reg_rdata_o[IrqBitReset]    = reset_req_o;
      end
      RegTxnId:   reg_rdata_o[IdWidth-1:0] = txn_id_q;
      RegLatency: reg_rdata_o = latency_q;
      default:    reg_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/txn_table.sv ====
/*
  Transaction table
  Holds the head/tail and linked-data tables and counts down the budget
  of every occupied record on each prescaler tick
*/
`default_nettype none

module txn_table import wr_monitor_pkg::*; #(
  parameter int unsigned MaxWrTxns    = 4,
  parameter int unsigned HtCapacity   = 4,
  parameter int unsigned PrescalerDiv = 1
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  head_tail_t [HtCapacity-1:0]  head_tail_d_i,
  input  linked_data_t [MaxWrTxns-1:0] linked_data_d_i,
  output head_tail_t [HtCapacity-1:0]  head_tail_q_o,
  output linked_data_t [MaxWrTxns-1:0] linked_data_q_o
);

  localparam int unsigned PsWidth = (PrescalerDiv > 1) ? $clog2(PrescalerDiv) : 1;

  logic [PsWidth-1:0] ps_q;
  logic               tick;

  assign tick = (ps_q == PsWidth'(PrescalerDiv - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ps_q <= '0;
    end else if (tick) begin
      ps_q <= '0;
    end else begin
      ps_q <= ps_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int h = 0; h < HtCapacity; h++) begin
        head_tail_q_o[h] <= HtEmpty;
      end
      for (int i = 0; i < MaxWrTxns; i++) begin
        linked_data_q_o[i] <= LdEmpty;
      end
    end else begin
      head_tail_q_o <= head_tail_d_i;
      for (int i = 0; i < MaxWrTxns; i++) begin
        linked_data_q_o[i] <= linked_data_d_i[i];
        // Counter holds at zero until the manager reacts
        if (tick && !linked_data_d_i[i].free && linked_data_d_i[i].counter != '0) begin
          linked_data_q_o[i].counter <= linked_data_d_i[i].counter - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/txn_manager.sv ====
/*
  Transaction manager
  Next-state logic of both tables: timeout, B matching, flush, dequeue
  and enqueue, plus the gate on the AW handshake
*/
`default_nettype none

module txn_manager import wr_monitor_pkg::*; #(
  parameter int unsigned MaxWrTxns    = 4,
  parameter int unsigned HtCapacity   = 4,
  parameter int unsigned PrescalerDiv = 1
) (
  input  logic                         aw_valid_i,
  input  logic                         aw_ready_i,
  input  id_t                          aw_id_i,
  input  len_t                         aw_len_i,
  input  logic                         b_valid_i,
  input  logic                         b_ready_i,
  input  id_t                          b_id_i,
  output logic                         aw_valid_o,
  output logic                         aw_ready_o,
  input  logic [BudgetWidth-1:0]       budget_write_i,
  input  accu_cnt_t                    accum_burst_length_i,
  input  logic                         reset_req_q_i,
  input  logic                         no_in_match_i,
  input  idx_t                         in_idx_i,
  input  logic                         no_out_match_i,
  input  idx_t                         out_idx_i,
  input  idx_t                         ht_free_idx_i,
  input  logic                         ht_free_i,
  input  idx_t                         ld_free_idx_i,
  input  logic                         ld_free_i,
  input  head_tail_t [HtCapacity-1:0]  head_tail_q_i,
  input  linked_data_t [MaxWrTxns-1:0] linked_data_q_i,
  output id_t                          match_in_id_o,
  output id_t                          match_out_id_o,
  output head_tail_t [HtCapacity-1:0]  head_tail_d_o,
  output linked_data_t [MaxWrTxns-1:0] linked_data_d_o,
  output logic                         timeout_evt_o,
  output logic                         unwanted_evt_o,
  output logic                         done_evt_o,
  output accu_cnt_t                    done_latency_o,
  output id_t                          evt_id_o
);

  logic [MaxWrTxns-1:0] is_head;
  logic      deq_valid, deq_ok, deq_more, ht_pop;
  idx_t      deq_idx;
  id_t       timeout_id;
  logic      b_hs, b_hit, flush, gate_open, aw_hs, new_q;
  idx_t      b_idx, ld_slot, ht_slot;
  accu_cnt_t bw_ext, beats, txn_budget;

  // Completed head record, records at the front of a queue, expired records
  always_comb begin
    is_head        = '0;
    deq_valid      = 1'b0;
    deq_idx        = '0;
    match_out_id_o = '0;
    timeout_evt_o  = 1'b0;
    timeout_id     = '0;
    for (int i = 0; i < MaxWrTxns; i++) begin
      for (int h = 0; h < HtCapacity; h++) begin
        if (!head_tail_q_i[h].free && head_tail_q_i[h].head == idx_t'(i)) begin
          is_head[i] = 1'b1;
        end
      end
      if (!linked_data_q_i[i].free && linked_data_q_i[i].found_match) begin
        deq_valid      = 1'b1;
        deq_idx        = idx_t'(i);
        match_out_id_o = linked_data_q_i[i].metadata.id;
      end
      if (!linked_data_q_i[i].free && !linked_data_q_i[i].found_match &&
          linked_data_q_i[i].counter == '0) begin
        timeout_evt_o = 1'b1;
        timeout_id    = linked_data_q_i[i].metadata.id;
      end
    end
  end

  assign deq_ok   = deq_valid && !no_out_match_i;
  assign ht_pop   = deq_ok && (head_tail_q_i[out_idx_i].head == head_tail_q_i[out_idx_i].tail);
  assign deq_more = deq_ok && (head_tail_q_i[out_idx_i].tail != deq_idx);

  // A B response belongs to the oldest not yet matched write of its ID
  assign b_hs = b_valid_i && b_ready_i;
  always_comb begin
    b_hit = 1'b0;
    b_idx = '0;
    for (int i = 0; i < MaxWrTxns; i++) begin
      if (b_hs && !linked_data_q_i[i].free && !linked_data_q_i[i].found_match &&
          linked_data_q_i[i].metadata.id == b_id_i &&
          (is_head[i] || (deq_more && linked_data_q_i[deq_idx].next == idx_t'(i)))) begin
        b_hit = 1'b1;
        b_idx = idx_t'(i);
      end
    end
  end

  assign unwanted_evt_o = b_hs && !b_hit;
  assign evt_id_o       = timeout_evt_o ? timeout_id : b_id_i;
  assign flush          = reset_req_q_i || timeout_evt_o || unwanted_evt_o;

  // Slots freed by this cycle's dequeue count as free
  assign gate_open     = !flush && (ld_free_i || deq_ok) && (ht_free_i || ht_pop);
  assign aw_valid_o    = aw_valid_i && gate_open;
  assign aw_ready_o    = aw_ready_i && gate_open;
  assign aw_hs         = aw_valid_i && aw_ready_i && gate_open;
  assign match_in_id_o = aw_id_i;

  // Budget counts the record itself, hence the final +1
  assign bw_ext     = accu_cnt_t'(budget_write_i);
  assign beats      = accu_cnt_t'(aw_len_i) + accu_cnt_t'(1);
  assign txn_budget = bw_ext * accum_burst_length_i +
                      accu_cnt_t'((bw_ext * beats) / PrescalerDiv) + accu_cnt_t'(1);

  // Queue of the popped ID is rebuilt in place when the same ID enqueues
  assign new_q   = no_in_match_i || (ht_pop && (in_idx_i == out_idx_i));
  assign ld_slot = ld_free_i ? ld_free_idx_i : deq_idx;
  assign ht_slot = !no_in_match_i ? in_idx_i : (ht_free_i ? ht_free_idx_i : out_idx_i);

  always_comb begin
    head_tail_d_o   = head_tail_q_i;
    linked_data_d_o = linked_data_q_i;
    done_evt_o      = 1'b0;
    done_latency_o  = '0;

    if (flush) begin
      for (int i = 0; i < MaxWrTxns; i++) begin
        linked_data_d_o[i] = LdEmpty;
      end
      for (int h = 0; h < HtCapacity; h++) begin
        head_tail_d_o[h] = HtEmpty;
      end
    end else begin
      if (deq_ok) begin
        done_evt_o               = 1'b1;
        done_latency_o           = linked_data_q_i[deq_idx].counter;
        linked_data_d_o[deq_idx] = LdEmpty;
        if (ht_pop) begin
          head_tail_d_o[out_idx_i] = HtEmpty;
        end else begin
          head_tail_d_o[out_idx_i].head = linked_data_q_i[deq_idx].next;
        end
      end
      if (b_hit) begin
        linked_data_d_o[b_idx].found_match = 1'b1;
      end
    end

    if (aw_hs) begin
      linked_data_d_o[ld_slot] = '{
        metadata:    '{id: aw_id_i, len: aw_len_i},
        counter:     txn_budget,
        found_match: 1'b0,
        next:        '0,
        free:        1'b0
      };
      if (new_q) begin
        head_tail_d_o[ht_slot] = '{id: aw_id_i, head: ld_slot, tail: ld_slot, free: 1'b0};
      end else begin
        linked_data_d_o[head_tail_q_i[in_idx_i].tail].next = ld_slot;
        head_tail_d_o[in_idx_i].tail = ld_slot;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ht_lookup.sv ====
/*
  Head/tail lookup
  Associative ID search over the per-ID queues and lowest-free-slot
  encoding for both tables
*/
`default_nettype none

module ht_lookup import wr_monitor_pkg::*; #(
  parameter int unsigned MaxWrTxns  = 4,
  parameter int unsigned HtCapacity = 4
) (
  input  head_tail_t [HtCapacity-1:0]  head_tail_q_i,
  input  linked_data_t [MaxWrTxns-1:0] linked_data_q_i,
  input  id_t                          match_in_id_i,
  input  id_t                          match_out_id_i,
  output logic                         no_in_match_o,
  output idx_t                         in_idx_o,
  output logic                         no_out_match_o,
  output idx_t                         out_idx_o,
  output idx_t                         ht_free_idx_o,
  output logic                         ht_free_o,
  output idx_t                         ld_free_idx_o,
  output logic                         ld_free_o
);

  // ID search, only occupied queues take part
  always_comb begin
    no_in_match_o  = 1'b1;
    in_idx_o       = '0;
    no_out_match_o = 1'b1;
    out_idx_o      = '0;
    for (int h = 0; h < HtCapacity; h++) begin
      if (!head_tail_q_i[h].free && head_tail_q_i[h].id == match_in_id_i) begin
        no_in_match_o = 1'b0;
        in_idx_o      = idx_t'(h);
      end
      if (!head_tail_q_i[h].free && head_tail_q_i[h].id == match_out_id_i) begin
        no_out_match_o = 1'b0;
        out_idx_o      = idx_t'(h);
      end
    end
  end

  // Scan downwards so the lowest free slot wins
  always_comb begin
    ht_free_o     = 1'b0;
    ht_free_idx_o = '0;
    for (int h = HtCapacity - 1; h >= 0; h--) begin
      if (head_tail_q_i[h].free) begin
        ht_free_o     = 1'b1;
        ht_free_idx_o = idx_t'(h);
      end
    end
  end

  always_comb begin
    ld_free_o     = 1'b0;
    ld_free_idx_o = '0;
    for (int i = MaxWrTxns - 1; i >= 0; i--) begin
      if (linked_data_q_i[i].free) begin
        ld_free_o     = 1'b1;
        ld_free_idx_o = idx_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wr_monitor_pkg.sv ====
/*
  Write monitor package
  Shared widths, table record types, register map and status bit positions
*/
`default_nettype none

package wr_monitor_pkg;

  localparam int unsigned IdWidth      = 4;
  localparam int unsigned LenWidth     = 8;
  localparam int unsigned CntWidth     = 16;
  localparam int unsigned IdxWidth     = 4;
  localparam int unsigned BudgetWidth  = 3;
  localparam int unsigned RegAddrWidth = 3;
  localparam int unsigned RegDataWidth = 16;

  typedef logic [IdWidth-1:0]  id_t;
  typedef logic [LenWidth-1:0] len_t;
  typedef logic [CntWidth-1:0] accu_cnt_t;
  typedef logic [IdxWidth-1:0] idx_t;

  typedef struct packed {
    id_t  id;
    len_t len;
  } metadata_t;

  // One outstanding write, chained to the next write of the same ID
  typedef struct packed {
    metadata_t metadata;
    accu_cnt_t counter;
    logic      found_match;
    idx_t      next;
    logic      free;
  } linked_data_t;

  // One per-ID queue
  typedef struct packed {
    id_t  id;
    idx_t head;
    idx_t tail;
    logic free;
  } head_tail_t;

  localparam linked_data_t LdEmpty =
    '{metadata: '0, counter: '0, found_match: 1'b0, next: '0, free: 1'b1};
  localparam head_tail_t HtEmpty = '{id: '0, head: '0, tail: '0, free: 1'b1};

  // Register map
  localparam logic [RegAddrWidth-1:0] RegBudget  = 3'd0;
  localparam logic [RegAddrWidth-1:0] RegAccum   = 3'd1;
  localparam logic [RegAddrWidth-1:0] RegIrq     = 3'd2;
  localparam logic [RegAddrWidth-1:0] RegTxnId   = 3'd3;
  localparam logic [RegAddrWidth-1:0] RegLatency = 3'd4;

  // Status bits in RegIrq
  localparam int unsigned IrqBitTimeout  = 0;
  localparam int unsigned IrqBitUnwanted = 1;
  localparam int unsigned IrqBitIrq      = 2;
  localparam int unsigned IrqBitReset    = 3;

endpackage

`default_nettype wire
